/* verilog/mlkem_arith_pkg.sv */
package mlkem_arith_pkg;

    // --------------------------------------------------------------------------
    // Modulus and widths
    // --------------------------------------------------------------------------

    // ML-KEM modulus
    localparam int MLKEM_Q = 3329;
    // Reduced share width
    localparam int MLKEM_Q_WIDTH = 12;
    // Input share width, Barrett shift k = 24
    localparam int MASKED_REG_SIZE = 24;
    // Clock edges from x to y
    localparam int REDC_LATENCY = 6;

    // --------------------------------------------------------------------------
    // Share bundles
    // --------------------------------------------------------------------------

    // Two arithmetic shares of x, summed mod 2^24
    typedef struct packed {
        logic [MASKED_REG_SIZE-1:0] x1;
        logic [MASKED_REG_SIZE-1:0] x0;
    } in_shares_t;

    // Two arithmetic shares of the result, summed mod 2^12
    typedef struct packed {
        logic [MLKEM_Q_WIDTH-1:0] y1;
        logic [MLKEM_Q_WIDTH-1:0] y0;
    } out_shares_t;

    // Fresh randomness consumed by the pipeline each cycle
    typedef struct packed {
        logic        rnd_1bit;
        logic [13:0] rnd_bool1;
        logic [13:0] rnd_bool0;
        logic [13:0] rnd_14bit;
        logic [11:0] rnd_12bit;
    } mask_rnd_t;

endpackage

/* verilog/redc_bus_pkg.sv */
package redc_bus_pkg;

    // --------------------------------------------------------------------------
    // Wishbone classic
    // --------------------------------------------------------------------------

    typedef struct packed {
        logic        cyc;
        logic        stb;
        logic        we;
        logic [2:0]  adr;
        logic [31:0] dat;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Word addresses of the register file
    typedef enum logic [2:0] {
        X0     = 3'd0,
        X1     = 3'd1,
        CTRL   = 3'd2,
        STATUS = 3'd3,
        Y0     = 3'd4,
        Y1     = 3'd5
    } redc_reg_e;

    // Sequencer states
    typedef enum logic [1:0] {
        IDLE,
        RUN,
        DONE
    } redc_state_e;

endpackage

/* verilog/mask_prng.sv */
`timescale 1ns/100ps

module mask_prng (
    input  logic                       clk,
    input  logic                       rst_n,
    output mlkem_arith_pkg::mask_rnd_t rnd
);

    logic [66:0] state;
    logic        fb;

    // Taps 67, 66, 58, 57 give a maximal length sequence
    assign fb = state[66] ^ state[65] ^ state[57] ^ state[56];

    // Free running, zeroize leaves it alone
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            // All ones, any nonzero seed works
            state <= '1;
        end else begin
            state <= {state[65:0], fb};
        end
    end

    assign rnd = mlkem_arith_pkg::mask_rnd_t'(state[$bits(mlkem_arith_pkg::mask_rnd_t)-1:0]);

endmodule

/* verilog/masked_cond_sub.sv */
`timescale 1ns/100ps

module masked_cond_sub (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       zeroize,
    input  logic [1:0][13:0]           c_rolled,
    input  mlkem_arith_pkg::mask_rnd_t rnd,
    output logic [1:0][11:0]           arith_q
);

    logic [13:0] a_q;
    logic [13:0] r_q;
    logic [13:0] xb;
    logic [13:0] b0;
    logic [13:0] b1;
    logic        s0;
    logic        s1;
    logic [11:0] u_next;
    logic [11:0] u_q;
    logic [11:0] rr_q;
    logic        sel_q;
    logic [11:0] q12;

    // Goubin arithmetic to Boolean, x = a + r gives x = result ^ r
    function automatic logic [13:0] a2b(
        input logic [13:0] a,
        input logic [13:0] r,
        input logic [13:0] g
    );
        logic [13:0] gam;
        logic [13:0] tt;
        logic [13:0] xo;
        logic [13:0] om;
        gam = g;
        tt  = gam << 1;
        xo  = gam ^ r;
        om  = gam & xo;
        xo  = tt ^ a;
        gam = gam ^ xo;
        gam = gam & r;
        om  = om ^ gam;
        gam = tt & a;
        om  = om ^ gam;
        // Masked ripple of the carry chain
        for (int k = 1; k < 14; k++) begin
            gam = tt & r;
            gam = gam ^ om;
            tt  = tt & a;
            gam = gam ^ tt;
            tt  = gam << 1;
        end
        return xo ^ tt;
    endfunction

    assign q12 = 12'(mlkem_arith_pkg::MLKEM_Q);

    // --------------------------------------------------------------------------
    // Stage 2, Boolean shares and masked sign bit
    // --------------------------------------------------------------------------
    always_comb begin
        xb = a2b(a_q, r_q, rnd.rnd_bool0);
        // Refresh before picking bit 12
        b0 = xb ^ rnd.rnd_bool1;
        b1 = r_q ^ rnd.rnd_bool1;
        s0 = b0[12] ^ rnd.rnd_1bit;
        s1 = b1[12] ^ rnd.rnd_1bit;
        // Share 0 depends on s0 only, s1 is applied next cycle
        u_next = (s0 ? q12 : 12'd0) - rnd.rnd_12bit;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            a_q     <= '0;
            r_q     <= '0;
            u_q     <= '0;
            rr_q    <= '0;
            sel_q   <= 1'b0;
            arith_q <= '0;
        end else if (zeroize) begin
            a_q     <= '0;
            r_q     <= '0;
            u_q     <= '0;
            rr_q    <= '0;
            sel_q   <= 1'b0;
            arith_q <= '0;
        end else begin
            // Stage 1, arithmetic refresh
            a_q   <= c_rolled[0] + rnd.rnd_14bit;
            r_q   <= c_rolled[1] - rnd.rnd_14bit;
            u_q   <= u_next;
            rr_q  <= rnd.rnd_12bit;
            sel_q <= s1;
            // Stage 3, s1 set flips q*s0 into q*(1-s0)
            arith_q[0] <= sel_q ? -u_q : u_q;
            arith_q[1] <= sel_q ? q12 - rr_q : rr_q;
        end
    end

endmodule

/* verilog/masked_barrett_reduction.sv */
`timescale 1ns/100ps

module masked_barrett_reduction (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          zeroize,
    input  mlkem_arith_pkg::in_shares_t   x,
    input  mlkem_arith_pkg::mask_rnd_t    rnd,
    output mlkem_arith_pkg::out_shares_t  y
);

    logic [1:0][36:0] tmp;
    logic [24:0]      lo_sum;
    logic [24:0]      x_sum;
    logic             carry;
    logic             wrap;
    logic [1:0][12:0] t_next;
    logic [1:0][12:0] t;
    logic [1:0][12:0] x_lo;
    logic [1:0][12:0] c_next;
    logic [1:0][12:0] c;
    logic [1:0][13:0] c_rolled;
    logic [1:0][11:0] arith_q;
    // c waits here while the comparison runs
    logic [1:0][12:0] c_dly [2:0];

    // x * mu with mu = 5039 = floor(2^24 / q)
    function automatic logic [36:0] mul_mu(input logic [23:0] v);
        logic [36:0] w;
        w = 37'(v);
        return (w << 12) + (w << 9) + (w << 8) + (w << 7) + (w << 5) + (w << 3)
            + (w << 2) + (w << 1) + w;
    endfunction

    // --------------------------------------------------------------------------
    // Stage 1, quotient estimate per share
    // --------------------------------------------------------------------------
    always_comb begin
        tmp[0] = mul_mu(x.x0);
        tmp[1] = mul_mu(x.x1);
        // Carry lost when the low halves are dropped separately
        lo_sum = {1'b0, tmp[0][23:0]} + {1'b0, tmp[1][23:0]};
        carry  = lo_sum[24];
        // Shares wrap mod 2^24, which would add mu to the quotient sum
        x_sum  = {1'b0, x.x0} + {1'b0, x.x1};
        wrap   = x_sum[24];
        // Both corrections go into share 0
        t_next[0] = tmp[0][36:24] + 13'(carry) - 13'(mul_mu({23'd0, wrap}));
        t_next[1] = tmp[1][36:24];
    end

    // --------------------------------------------------------------------------
    // Stage 2, c = x - q*t mod 2^13, then roll by 2^12 - q
    // --------------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < 2; i++) begin
            c_next[i] = x_lo[i] - t[i] * 13'(mlkem_arith_pkg::MLKEM_Q);
        end
        // Bit 12 of the rolled sum is set exactly when c >= q
        c_rolled[0] = {1'b0, c[0]}
            + 14'((1 << mlkem_arith_pkg::MLKEM_Q_WIDTH) - mlkem_arith_pkg::MLKEM_Q);
        c_rolled[1] = {1'b0, c[1]};
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            t     <= '0;
            x_lo  <= '0;
            c     <= '0;
            c_dly <= '{default: '0};
        end else if (zeroize) begin
            t     <= '0;
            x_lo  <= '0;
            c     <= '0;
            c_dly <= '{default: '0};
        end else begin
            t        <= t_next;
            // Only the low 13 bits survive the mod 2^13 subtraction
            x_lo[0]  <= x.x0[12:0];
            x_lo[1]  <= x.x1[12:0];
            c        <= c_next;
            c_dly[2] <= c;
            c_dly[1] <= c_dly[2];
            c_dly[0] <= c_dly[1];
        end
    end

    // Stages 3 to 5, shares of q or of zero
    masked_cond_sub cond_sub_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .zeroize  (zeroize),
        .c_rolled (c_rolled),
        .rnd      (rnd),
        .arith_q  (arith_q)
    );

    // Stage 6, y = c - (q or 0), one share at a time
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y <= '0;
        end else if (zeroize) begin
            y <= '0;
        end else begin
            y.y0 <= c_dly[0][0][11:0] - arith_q[0];
            y.y1 <= c_dly[0][1][11:0] - arith_q[1];
        end
    end

endmodule

/* verilog/redc_latency_timer.sv */
`timescale 1ns/100ps

module redc_latency_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic load,
    input  logic zeroize,
    output logic expired
);

    // Zero means idle
    logic [2:0] cnt;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt <= '0;
        end else if (zeroize) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= 3'(mlkem_arith_pkg::REDC_LATENCY);
        end else if (cnt != 3'd0) begin
            cnt <= cnt - 3'd1;
        end
    end

    assign expired = (cnt == 3'd1);

endmodule

/* verilog/redc_ctrl_fsm.sv */
`timescale 1ns/100ps

module redc_ctrl_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic start,
    input  logic zeroize,
    input  logic expired,
    output logic timer_load,
    output logic capture,
    output logic busy,
    output logic done
);

    redc_bus_pkg::redc_state_e state;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= redc_bus_pkg::IDLE;
            timer_load <= 1'b0;
        end else begin
            timer_load <= 1'b0;
            // Zeroize wins over everything
            if (zeroize) begin
                state <= redc_bus_pkg::IDLE;
            end else begin
                case (state)
                    redc_bus_pkg::IDLE, redc_bus_pkg::DONE: begin
                        if (start) begin
                            state      <= redc_bus_pkg::RUN;
                            timer_load <= 1'b1;
                        end
                    end
                    // Start is dropped here
                    redc_bus_pkg::RUN: begin
                        if (expired) begin
                            state <= redc_bus_pkg::DONE;
                        end
                    end
                    default: begin
                        state <= redc_bus_pkg::IDLE;
                    end
                endcase
            end
        end
    end

    // Result latch pulse on the last RUN cycle
    assign capture = (state == redc_bus_pkg::RUN) && expired;
    assign busy    = (state == redc_bus_pkg::RUN);
    assign done    = (state == redc_bus_pkg::DONE);

endmodule

/* verilog/redc_regfile.sv */
`timescale 1ns/100ps

module redc_regfile (
    input  logic                         clk,
    input  logic                         rst_n,
    input  redc_bus_pkg::wb_req_t        wb_req,
    output redc_bus_pkg::wb_rsp_t        wb_rsp,
    input  logic                         busy,
    input  logic                         done,
    input  logic                         capture,
    input  mlkem_arith_pkg::out_shares_t result,
    output mlkem_arith_pkg::in_shares_t  operands,
    output logic                         start,
    output logic                         zeroize
);

    localparam int XW = mlkem_arith_pkg::MASKED_REG_SIZE;

    redc_bus_pkg::redc_reg_e      reg_sel;
    logic                         accept;
    logic                         ack;
    logic [31:0]                  rdat;
    logic [31:0]                  rd_word;
    mlkem_arith_pkg::in_shares_t  x_q;
    mlkem_arith_pkg::out_shares_t y_q;

    assign reg_sel = redc_bus_pkg::redc_reg_e'(wb_req.adr);
    // One access per ack, next one only once ack has dropped
    assign accept  = wb_req.cyc && wb_req.stb && !ack;

    // Read mux
    always_comb begin
        case (reg_sel)
            redc_bus_pkg::X0:     rd_word = 32'(x_q.x0);
            redc_bus_pkg::X1:     rd_word = 32'(x_q.x1);
            redc_bus_pkg::STATUS: rd_word = {30'd0, done, busy};
            redc_bus_pkg::Y0:     rd_word = 32'(y_q.y0);
            redc_bus_pkg::Y1:     rd_word = 32'(y_q.y1);
            default:              rd_word = '0;
        endcase
    end

    // --------------------------------------------------------------------------
    // Bus side, ack, operands and control pulses
    // --------------------------------------------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ack     <= 1'b0;
            rdat    <= '0;
            x_q     <= '0;
            start   <= 1'b0;
            zeroize <= 1'b0;
        end else begin
            ack     <= accept;
            start   <= 1'b0;
            zeroize <= 1'b0;
            if (accept && wb_req.we) begin
                case (reg_sel)
                    redc_bus_pkg::X0: x_q.x0 <= wb_req.dat[XW-1:0];
                    redc_bus_pkg::X1: x_q.x1 <= wb_req.dat[XW-1:0];
                    redc_bus_pkg::CTRL: begin
                        start   <= wb_req.dat[0];
                        zeroize <= wb_req.dat[1];
                    end
                    default: begin
                    end
                endcase
            end
            if (accept && !wb_req.we) begin
                rdat <= rd_word;
            end
        end
    end

    // Result shares, cleared by zeroize
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            y_q <= '0;
        end else if (zeroize) begin
            y_q <= '0;
        end else if (capture) begin
            y_q <= result;
        end
    end

    assign wb_rsp.ack = ack;
    assign wb_rsp.dat = rdat;
    assign operands   = x_q;

endmodule

/* verilog/redc_top.sv */
`timescale 1ns/100ps

module redc_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  redc_bus_pkg::wb_req_t wb_req,
    output redc_bus_pkg::wb_rsp_t wb_rsp
);

    mlkem_arith_pkg::in_shares_t  operands;
    mlkem_arith_pkg::out_shares_t result;
    mlkem_arith_pkg::mask_rnd_t   rnd;
    logic start;
    logic zeroize;
    logic busy;
    logic done;
    logic capture;
    logic timer_load;
    logic expired;

    redc_regfile regfile_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_req   (wb_req),
        .wb_rsp   (wb_rsp),
        .busy     (busy),
        .done     (done),
        .capture  (capture),
        .result   (result),
        .operands (operands),
        .start    (start),
        .zeroize  (zeroize)
    );

    redc_ctrl_fsm ctrl_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .start      (start),
        .zeroize    (zeroize),
        .expired    (expired),
        .timer_load (timer_load),
        .capture    (capture),
        .busy       (busy),
        .done       (done)
    );

    redc_latency_timer timer_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .load    (timer_load),
        .zeroize (zeroize),
        .expired (expired)
    );

    mask_prng prng_i (
        .clk   (clk),
        .rst_n (rst_n),
        .rnd   (rnd)
    );

    masked_barrett_reduction redc_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .zeroize (zeroize),
        .x       (operands),
        .rnd     (rnd),
        .y       (result)
    );

endmodule

/* sim/tb_redc.sv */
`timescale 1ns/100ps

module tb_redc;

    // Watchdog budget per reduction, in clock cycles
    localparam int CYCLES_PER_RUN = 40;
    localparam int CLK_PERIOD     = 8;
    localparam int MAX_POLLS      = 40;

    logic                  clk;
    logic                  rst_n;
    redc_bus_pkg::wb_req_t wb_req;
    redc_bus_pkg::wb_rsp_t wb_rsp;

    // Cases from the data file
    string       case_name[$];
    logic [23:0] case_x0[$];
    logic [23:0] case_x1[$];
    logic [11:0] case_exp[$];
    bit          cases_loaded;

    int errors;
    int tests_passed;
    int tests_failed;

    redc_top dut_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // ------------------------------------------------------------------------
    // Wishbone host side, drive on the falling edge and hold until ack
    // ------------------------------------------------------------------------
    task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b1;
        wb_req.adr = adr;
        wb_req.dat = dat;
        do begin
            @(negedge clk);
        end while (!wb_rsp.ack);
        wb_req = '0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
        @(negedge clk);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we  = 1'b0;
        wb_req.adr = adr;
        wb_req.dat = '0;
        do begin
            @(negedge clk);
        end while (!wb_rsp.ack);
        // Read data comes with ack
        dat    = wb_rsp.dat;
        wb_req = '0;
    endtask

    task automatic read_and_compare(input string name, input logic [2:0] adr,
                                    input logic [31:0] exp_val);
        logic [31:0] rd;
        wb_read(adr, rd);
        if (rd !== exp_val) begin
            $display("Error %s: expected %0h actual %0h", name, exp_val, rd);
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("PASS  %s", name);
        end else begin
            tests_failed++;
            $display("FAIL  %s", name);
        end
    endtask

    // Polls STATUS until done rises
    task automatic wait_done(input string name, output bit seen);
        logic [31:0] st;
        int          polls;
        seen  = 1'b0;
        polls = 0;
        while (!seen && polls < MAX_POLLS) begin
            wb_read(redc_bus_pkg::STATUS, st);
            seen = st[1];
            polls++;
        end
        if (!seen) begin
            $display("%s: done did not rise within %0d status reads", name, MAX_POLLS);
            errors++;
        end
    endtask

    // One full reduction, result checked as y0 + y1 mod 4096
    task automatic run_reduction(input string name, input logic [23:0] x0,
                                 input logic [23:0] x1, input logic [11:0] exp_val,
                                 input bit restart);
        logic [31:0] st;
        logic [31:0] y0;
        logic [31:0] y1;
        logic [11:0] got;
        bit          seen;
        wb_write(redc_bus_pkg::X0, 32'(x0));
        wb_write(redc_bus_pkg::X1, 32'(x1));
        wb_write(redc_bus_pkg::CTRL, 32'h1);
        // Second start lands in RUN after X0 has changed under it
        // A restarted run would pick up the new X0 and give another sum
        if (restart) begin
            wb_write(redc_bus_pkg::X0, 32'(x0 ^ 24'h1));
            wb_write(redc_bus_pkg::CTRL, 32'h1);
        end
        // Busy and not done right after the start
        wb_read(redc_bus_pkg::STATUS, st);
        if (st !== 32'h1) begin
            $display("Error %s: expected status %0h actual %0h", name, 32'h1, st);
            errors++;
        end
        wait_done(name, seen);
        if (seen) begin
            wb_read(redc_bus_pkg::Y0, y0);
            wb_read(redc_bus_pkg::Y1, y1);
            got = y0[11:0] + y1[11:0];
            if (got !== exp_val) begin
                $display("Error %s: expected %0d actual %0d", name, exp_val, got);
                errors++;
            end
            // Done holds until the next start
            wb_read(redc_bus_pkg::STATUS, st);
            if (st !== 32'h2) begin
                $display("Error %s: expected status %0h actual %0h", name, 32'h2, st);
                errors++;
            end
        end
    endtask

    // ------------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------------
    initial begin
        longint limit_ns;
        wait (cases_loaded);
        // Four reductions per case, plus room for the fixed tests and reset
        limit_ns = longint'(case_name.size() * 4 + 10) * CYCLES_PER_RUN * CLK_PERIOD + 2000;
        #(limit_ns);
        $display("Timeout: the run was still going after %0d ns", limit_ns);
        $display("TEST FAIL");
        $finish;
    end

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        int               fd;
        int               r;
        bit               eof_seen;
        string            tok;
        logic [8*128-1:0] line;
        logic [23:0]      a;
        logic [23:0]      b;
        logic [11:0]      e;
        logic [23:0]      total;
        logic [23:0]      s0;
        int               errs_before;
        int               last;
        int unsigned      seed;

        clk          = 1'b0;
        rst_n        = 1'b0;
        wb_req       = '0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        cases_loaded = 1'b0;
        seed         = $urandom(32'hada1);

        // Case file, lines starting with # are skipped
        fd = $fopen("sim/redc_cases.txt", "r");
        if (fd == 0) begin
            $display("Could not open sim/redc_cases.txt");
            errors++;
        end else begin
            eof_seen = 1'b0;
            while (!eof_seen) begin
                r = $fscanf(fd, "%s", tok);
                if (r != 1) begin
                    eof_seen = 1'b1;
                end else if (tok.substr(0, 0) == "#") begin
                    r = $fgets(line, fd);
                end else begin
                    r = $fscanf(fd, "%h %h %h", a, b, e);
                    if (r == 3) begin
                        case_name.push_back(tok);
                        case_x0.push_back(a);
                        case_x1.push_back(b);
                        case_exp.push_back(e);
                    end else begin
                        $display("Case %s has a malformed line", tok);
                        errors++;
                    end
                end
            end
            $fclose(fd);
        end
        if (case_name.size() == 0) begin
            $display("No cases were loaded");
            errors++;
        end
        cases_loaded = 1'b1;

        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Everything reads zero out of reset
        errs_before = errors;
        read_and_compare("reset_status", redc_bus_pkg::STATUS, 32'h0);
        read_and_compare("reset_status", redc_bus_pkg::Y0, 32'h0);
        read_and_compare("reset_status", redc_bus_pkg::Y1, 32'h0);
        report_test("reset_status", errs_before);

        // Only the low 24 bits of an operand are kept
        errs_before = errors;
        wb_write(redc_bus_pkg::X0, 32'hffa5c3e1);
        wb_write(redc_bus_pkg::X1, 32'h125a3c1e);
        read_and_compare("readback", redc_bus_pkg::X0, 32'h00a5c3e1);
        read_and_compare("readback", redc_bus_pkg::X1, 32'h005a3c1e);
        report_test("readback", errs_before);

        if (case_name.size() > 0) begin
            foreach (case_name[i]) begin
                errs_before = errors;
                run_reduction($sformatf("reduce %s", case_name[i]), case_x0[i], case_x1[i],
                              case_exp[i], 1'b0);
                report_test($sformatf("reduce %s", case_name[i]), errs_before);
            end

            // Same total, three fresh random splits
            foreach (case_name[i]) begin
                errs_before = errors;
                total = case_x0[i] + case_x1[i];
                for (int k = 0; k < 3; k++) begin
                    s0 = 24'($urandom);
                    run_reduction($sformatf("remask %s", case_name[i]), s0, total - s0,
                                  case_exp[i], 1'b0);
                end
                report_test($sformatf("remask %s", case_name[i]), errs_before);
            end

            // Zeroize after a finished reduction, then one more reduction
            errs_before = errors;
            last = case_name.size() - 1;
            run_reduction("zeroize", case_x0[last], case_x1[last], case_exp[last], 1'b0);
            wb_write(redc_bus_pkg::CTRL, 32'h2);
            read_and_compare("zeroize", redc_bus_pkg::STATUS, 32'h0);
            read_and_compare("zeroize", redc_bus_pkg::Y0, 32'h0);
            read_and_compare("zeroize", redc_bus_pkg::Y1, 32'h0);
            run_reduction("zeroize", case_x0[last / 2], case_x1[last / 2],
                          case_exp[last / 2], 1'b0);
            report_test("zeroize", errs_before);

            // Start while busy
            errs_before = errors;
            run_reduction("ignored_start", case_x0[last], case_x1[last], case_exp[last], 1'b1);
            report_test("ignored_start", errs_before);
        end

        $display("Tests: %0d passed, %0d failed, %0d errors", tests_passed, tests_failed,
                 errors);
        if (errors == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

/* sim/redc_cases.txt */
# name  x0 (hex)  x1 (hex)  expected (hex)
# expected = ((x0 + x1) mod 2^24) mod 3329
zero          000000  000000  000
small         000001  000001  002
q_minus_1     000000  000D00  D00
q             000D01  000000  000
q_plus_1      000D00  000002  001
q_split       000680  000681  000
val_12345     003039  000000  936
mid           123456  654321  B48
mixed         0C0FFE  3F00D5  A0E
max           FFFFFF  000000  950
max_split     800000  7FFFFF  950
max_minus_1   7FFFFF  7FFFFF  94F
mult_top      FFF000  0006AF  000
mult_top_m1   FFF6AE  000000  D00
wrap_one      FFFFFF  000002  001
wrap_q        FFFFFF  000D02  000
wrap_mid      ABCDEF  800000  491

/* src.f */
verilog/mlkem_arith_pkg.sv
verilog/redc_bus_pkg.sv
verilog/mask_prng.sv
verilog/masked_cond_sub.sv
verilog/masked_barrett_reduction.sv
verilog/redc_latency_timer.sv
verilog/redc_ctrl_fsm.sv
verilog/redc_regfile.sv
verilog/redc_top.sv
sim/tb_redc.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module tb_redc -f src.f -o tb_redc_sim \
    && ./obj_dir/tb_redc_sim | tee sim.log \
    || { echo "Build or simulation did not complete"; exit 1; }

grep -qx "TEST PASS" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed, see sim.log"; exit 1; }
